// ==== common/mipsPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants and encodings for the MIPS memory-access stage.
// Only the eight standard load/store opcodes are known here.
// Anything else is treated as a non-memory instruction.
// Data memory depth must stay a power of two.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mipsPkg;

    // datapath widths
    localparam int instrWidth   = 32;
    localparam int tWidth       = 2;
    localparam int regAddrWidth = 5;

    // data memory geometry, counted in 32-bit words
    localparam int memWords     = 1024;
    localparam int memAddrWidth = $clog2(memWords);

    // opcode field sits in the top six bits of the instruction
    localparam int opWidth = 6;

    // loads
    localparam logic [opWidth-1:0] opLw  = 6'b100011;
    localparam logic [opWidth-1:0] opLh  = 6'b100001;
    localparam logic [opWidth-1:0] opLhu = 6'b100101;
    localparam logic [opWidth-1:0] opLb  = 6'b100000;
    localparam logic [opWidth-1:0] opLbu = 6'b100100;

    // stores
    localparam logic [opWidth-1:0] opSw  = 6'b101011;
    localparam logic [opWidth-1:0] opSh  = 6'b101001;
    localparam logic [opWidth-1:0] opSb  = 6'b101000;

    // what the instruction does with data memory
    // funcOther is zero so an all-zero nop decodes to it
    typedef enum logic [1:0] {
        funcOther    = 2'b00,
        funcMemRead  = 2'b01,
        funcMemWrite = 2'b10
    } memFunc_e;

    // width of the memory access
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } accSize_e;

endpackage

// ==== src/instrClass.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode classifier for the memory stage, purely combinational.
// Looks only at the opcode field; funct bits of R-type are ignored.
// Unknown opcodes report funcOther with word size and no sign extension.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module instrClass
    import mipsPkg::*;
(
    input  logic [instrWidth-1:0] instr,
    output memFunc_e              memFunc,
    output accSize_e              accSize,
    output logic                  loadSigned
);

    logic [opWidth-1:0] opcode;

    // top bits of the instruction word
    assign opcode = instr[instrWidth-1 -: opWidth];

    always_comb begin
        // anything not listed below is a plain ALU or branch op
        memFunc    = funcOther;
        accSize    = sizeWord;
        loadSigned = 1'b0;

        case (opcode)
            // loads
            opLw: begin
                memFunc = funcMemRead;
                accSize = sizeWord;
            end
            opLh: begin
                memFunc    = funcMemRead;
                accSize    = sizeHalf;
                loadSigned = 1'b1;
            end
            opLhu: begin
                memFunc = funcMemRead;
                accSize = sizeHalf;
            end
            opLb: begin
                memFunc    = funcMemRead;
                accSize    = sizeByte;
                loadSigned = 1'b1;
            end
            opLbu: begin
                memFunc = funcMemRead;
                accSize = sizeByte;
            end
            // stores, never sign-extended
            opSw: begin
                memFunc = funcMemWrite;
                accSize = sizeWord;
            end
            opSh: begin
                memFunc = funcMemWrite;
                accSize = sizeHalf;
            end
            opSb: begin
                memFunc = funcMemWrite;
                accSize = sizeByte;
            end
            default: begin
                memFunc = funcOther;
            end
        endcase
    end

endmodule

// ==== dm/dataMem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-organized data memory with byte-lane writes.
// Read is asynchronous, write lands on the rising clock edge.
// Contents are not initialized and are not cleared by reset.
// Misaligned or out-of-range stores are flagged by assertions only;
// the hardware silently uses the aligned word index.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dataMem
    import mipsPkg::*;
(
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    input  logic        wEn,
    input  accSize_e    accSize,
    input  logic        loadSigned,
    output logic [31:0] rData
);

    logic [31:0]             mem [memWords];
    logic [memAddrWidth-1:0] wordIdx;
    logic [1:0]              byteSel;
    logic [31:0]             curWord;
    logic [7:0]              rdByte;
    logic [15:0]             rdHalf;

    // byte address split into word index and lane
    assign wordIdx = addr[memAddrWidth+1:2];
    assign byteSel = addr[1:0];

    // lane-masked write
    always_ff @(posedge clk) begin
        if (wEn) begin
            case (accSize)
                sizeByte: begin
                    // low byte of wData into the addressed lane
                    mem[wordIdx][8*byteSel +: 8] <= wData[7:0];
                end
                sizeHalf: begin
                    // bit 1 picks upper or lower half
                    if (byteSel[1]) begin
                        mem[wordIdx][31:16] <= wData[15:0];
                    end else begin
                        mem[wordIdx][15:0] <= wData[15:0];
                    end
                end
                default: begin
                    mem[wordIdx] <= wData;
                end
            endcase
        end
    end

    // combinational read path
    assign curWord = mem[wordIdx];
    assign rdByte  = curWord[8*byteSel +: 8];
    assign rdHalf  = byteSel[1] ? curWord[31:16] : curWord[15:0];

    always_comb begin
        case (accSize)
            sizeByte: rData = {{24{loadSigned & rdByte[7]}}, rdByte};
            sizeHalf: rData = {{16{loadSigned & rdHalf[15]}}, rdHalf};
            default:  rData = curWord;
        endcase
    end

    // store checks, loads are checked where the opcode is known
    halfAligned: assert property (
        @(posedge clk) (wEn && accSize == sizeHalf) |-> (addr[0] == 1'b0)
    ) else $error("dataMem: halfword store to odd address %h", addr);

    wordAligned: assert property (
        @(posedge clk) (wEn && accSize == sizeWord) |-> (addr[1:0] == 2'b00)
    ) else $error("dataMem: word store to unaligned address %h", addr);

    // upper address bits must be zero or the index wraps
    inRange: assert property (
        @(posedge clk) wEn |-> (addr[31:memAddrWidth+2] == '0)
    ) else $error("dataMem: store address %h beyond memory", addr);

endmodule

// ==== src/memWbReg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM/WB pipeline register.
// Priority is reset, then clear, then stall; otherwise it loads.
// All outputs are zero after reset or clear, which reads as a nop.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module memWbReg
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    stall,
    input  logic                    clr,
    input  logic [instrWidth-1:0]   instrIn,
    input  logic [31:0]             pcIn,
    input  logic [31:0]             memWordIn,
    input  logic [regAddrWidth-1:0] regWriteAddrIn,
    input  logic [31:0]             regWriteDataIn,
    input  logic [tWidth-1:0]       tNewIn,
    output logic [instrWidth-1:0]   instrWb,
    output logic [31:0]             pcWb,
    output logic [31:0]             memWordWb,
    output logic [regAddrWidth-1:0] regWriteAddrWb,
    output logic [31:0]             regWriteDataWb,
    output logic [tWidth-1:0]       tNewWb
);

    always_ff @(posedge clk) begin
        if (!rstN || clr) begin
            // flush to a bubble
            instrWb        <= '0;
            pcWb           <= '0;
            memWordWb      <= '0;
            regWriteAddrWb <= '0;
            regWriteDataWb <= '0;
            tNewWb         <= '0;
        end else if (!stall) begin
            instrWb        <= instrIn;
            pcWb           <= pcIn;
            memWordWb      <= memWordIn;
            regWriteAddrWb <= regWriteAddrIn;
            regWriteDataWb <= regWriteDataIn;
            tNewWb         <= tNewIn;
        end
    end

    // a stalled edge must leave the whole WB payload untouched
    holdOnStall: assert property (
        @(posedge clk) (stall && rstN && !clr) |=>
            ($stable(instrWb) && $stable(pcWb) && $stable(memWordWb) &&
             $stable(regWriteAddrWb) && $stable(regWriteDataWb) && $stable(tNewWb))
    ) else $error("memWbReg: WB outputs changed during stall");

endmodule

// ==== src/memStage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-access stage of the five-stage MIPS pipeline, with MEM/WB register.
// Store data is forwarded from WB when WB writes the same nonzero register.
// Stores are blocked while stall is high so a held store writes only once.
// Loads read memory combinationally in their own cycle.
// No exceptions, no unaligned handling, no memory-mapped I/O.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module memStage
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    stall,
    input  logic                    clr,
    // from the execute stage
    input  logic [instrWidth-1:0]   instrMem,
    input  logic [31:0]             pcMem,
    input  logic [31:0]             aluOutMem,
    input  logic [31:0]             dataRtMem,
    input  logic [regAddrWidth-1:0] addrRtMem,
    input  logic [regAddrWidth-1:0] regWriteAddrMem,
    input  logic [31:0]             regWriteDataMem,
    input  logic [tWidth-1:0]       tNewMem,
    // writeback value in flight, for forwarding
    input  logic [regAddrWidth-1:0] regAddrWb,
    input  logic [31:0]             regDataWb,
    // to the writeback stage
    output logic [instrWidth-1:0]   instrWb,
    output logic [31:0]             pcWb,
    output logic [31:0]             memWordWb,
    output logic [regAddrWidth-1:0] regWriteAddrWb,
    output logic [31:0]             regWriteDataWb,
    output logic [tWidth-1:0]       tNewWb
);

    memFunc_e          memFunc;
    accSize_e          accSize;
    logic              loadSigned;
    logic [31:0]       storeData;
    logic              memWEn;
    logic [31:0]       memWord;
    logic [31:0]       regWriteData;
    logic [tWidth-1:0] tNewNext;

    instrClass uInstrClass (
        .instr      (instrMem),
        .memFunc    (memFunc),
        .accSize    (accSize),
        .loadSigned (loadSigned)
    );

    // $zero is never forwarded
    assign storeData = (regAddrWb == addrRtMem && regAddrWb != '0) ? regDataWb : dataRtMem;

    // no memory write while the stage is held
    assign memWEn = (memFunc == funcMemWrite) && !stall;

    dataMem uDataMem (
        .clk        (clk),
        .addr       (aluOutMem),
        .wData      (storeData),
        .wEn        (memWEn),
        .accSize    (accSize),
        .loadSigned (loadSigned),
        .rData      (memWord)
    );

    // Tnew counts down one per stage, floor at zero
    assign tNewNext = (tNewMem != '0) ? tNewMem - tWidth'(1) : '0;

    // loads write back the memory value
    assign regWriteData = (memFunc == funcMemRead) ? memWord : regWriteDataMem;

    memWbReg uMemWbReg (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .clr            (clr),
        .instrIn        (instrMem),
        .pcIn           (pcMem),
        .memWordIn      (memWord),
        .regWriteAddrIn (regWriteAddrMem),
        .regWriteDataIn (regWriteData),
        .tNewIn         (tNewNext),
        .instrWb        (instrWb),
        .pcWb           (pcWb),
        .memWordWb      (memWordWb),
        .regWriteAddrWb (regWriteAddrWb),
        .regWriteDataWb (regWriteDataWb),
        .tNewWb         (tNewWb)
    );

    // load alignment and range, decoded here and applied in dataMem
    loadAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        (memFunc == funcMemRead) |->
            ((accSize != sizeHalf || aluOutMem[0] == 1'b0) &&
             (accSize != sizeWord || aluOutMem[1:0] == 2'b00) &&
             (aluOutMem[31:memAddrWidth+2] == '0))
    ) else $error("memStage: bad load address %h", aluOutMem);

endmodule

// ==== bench/memStageTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the MIPS memory-access stage with its MEM/WB register.
// Inputs change on the falling edge. A reference model at the rising edge
// predicts the WB outputs, and concurrent assertions compare them.
// Loads only touch the first 64 words, which the fill test writes first.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module memStageTb
    import mipsPkg::*;
;

    localparam int watchdogNs = 200000;

    logic clk = 1'b0;
    logic rstN, stall, clr, chkOn;
    logic [31:0] instrMem, pcMem, aluOutMem, dataRtMem, regWriteDataMem, regDataWb;
    logic [4:0]  addrRtMem, regWriteAddrMem, regAddrWb;
    logic [1:0]  tNewMem;
    logic [31:0] instrWb, pcWb, memWordWb, regWriteDataWb;
    logic [4:0]  regWriteAddrWb;
    logic [1:0]  tNewWb;

    // reference model state
    logic [31:0] shadow [memWords];
    logic [31:0] expInstr, expPc, expMemWord, expRegData;
    logic [4:0]  expRegAddr;
    logic [1:0]  expTNew;
    logic        expMemChk;
    logic [31:0] lfsr;
    int          errCount = 0, errMark = 0, testsRun = 0, testsFailed = 0;

    always #10 clk = ~clk;

    memStage u_dut (
        .clk(clk), .rstN(rstN), .stall(stall), .clr(clr),
        .instrMem(instrMem), .pcMem(pcMem), .aluOutMem(aluOutMem),
        .dataRtMem(dataRtMem), .addrRtMem(addrRtMem),
        .regWriteAddrMem(regWriteAddrMem), .regWriteDataMem(regWriteDataMem),
        .tNewMem(tNewMem), .regAddrWb(regAddrWb), .regDataWb(regDataWb),
        .instrWb(instrWb), .pcWb(pcWb), .memWordWb(memWordWb),
        .regWriteAddrWb(regWriteAddrWb), .regWriteDataWb(regWriteDataWb), .tNewWb(tNewWb)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic isLoadOp(input logic [5:0] op);
        return op == opLw || op == opLh || op == opLhu || op == opLb || op == opLbu;
    endfunction

    function automatic logic isStoreOp(input logic [5:0] op);
        return op == opSw || op == opSh || op == opSb;
    endfunction

    // lane pick and extension as the opcode asks
    function automatic logic [31:0] predictLoad(input logic [5:0] op, input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  lane8;
        logic [15:0] lane16;
        word   = shadow[addr[memAddrWidth+1:2]];
        lane8  = word[8*addr[1:0] +: 8];
        lane16 = addr[1] ? word[31:16] : word[15:0];
        case (op)
            opLb:    return {{24{lane8[7]}}, lane8};
            opLbu:   return {24'd0, lane8};
            opLh:    return {{16{lane16[15]}}, lane16};
            opLhu:   return {16'd0, lane16};
            default: return word;
        endcase
    endfunction

    function automatic void storeShadow(input logic [5:0] op, input logic [31:0] addr,
                                        input logic [31:0] data);
        logic [memAddrWidth-1:0] idx;
        idx = addr[memAddrWidth+1:2];
        case (op)
            opSb: shadow[idx][8*addr[1:0] +: 8] = data[7:0];
            opSh: begin
                if (addr[1]) shadow[idx][31:16] = data[15:0];
                else shadow[idx][15:0] = data[15:0];
            end
            default: shadow[idx] = data;
        endcase
    endfunction

    // expected WB values for the next edge
    always @(posedge clk) begin : refModel
        logic [5:0]  op;
        logic [31:0] ldVal;
        logic [31:0] stData;
        op     = instrMem[31:26];
        ldVal  = predictLoad(op, aluOutMem);
        // forward from WB unless the target is $zero
        stData = (regAddrWb != 5'd0 && regAddrWb == addrRtMem) ? regDataWb : dataRtMem;
        if (!rstN || clr) begin
            expInstr   <= '0;
            expPc      <= '0;
            expMemWord <= '0;
            expRegAddr <= '0;
            expRegData <= '0;
            expTNew    <= '0;
            expMemChk  <= 1'b1;
        end else if (!stall) begin
            expInstr   <= instrMem;
            expPc      <= pcMem;
            expMemWord <= ldVal;
            expMemChk  <= isLoadOp(op);
            expRegAddr <= regWriteAddrMem;
            expRegData <= isLoadOp(op) ? ldVal : regWriteDataMem;
            expTNew    <= (tNewMem == 2'd0) ? 2'd0 : tNewMem - 2'd1;
            if (isStoreOp(op)) storeShadow(op, aluOutMem, stData);
        end
    end

    task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        errCount++;
        $display("[ERROR] %0t ns %s expected %h actual %h", $time, sigName, expVal, actVal);
    endtask

    chkInstr: assert property (@(posedge clk) disable iff (!chkOn) instrWb == expInstr)
        else reportMismatch("instrWb", $sampled(expInstr), $sampled(instrWb));
    chkPc: assert property (@(posedge clk) disable iff (!chkOn) pcWb == expPc)
        else reportMismatch("pcWb", $sampled(expPc), $sampled(pcWb));
    chkRegAddr: assert property (@(posedge clk) disable iff (!chkOn) regWriteAddrWb == expRegAddr)
        else reportMismatch("regWriteAddrWb", 32'($sampled(expRegAddr)),
                            32'($sampled(regWriteAddrWb)));
    chkRegData: assert property (@(posedge clk) disable iff (!chkOn) regWriteDataWb == expRegData)
        else reportMismatch("regWriteDataWb", $sampled(expRegData), $sampled(regWriteDataWb));
    chkTNew: assert property (@(posedge clk) disable iff (!chkOn) tNewWb == expTNew)
        else reportMismatch("tNewWb", 32'($sampled(expTNew)), 32'($sampled(tNewWb)));
    // memWordWb only matters after a load or a flush
    chkMemWord: assert property (@(posedge clk) disable iff (!chkOn)
        expMemChk |-> memWordWb == expMemWord)
        else reportMismatch("memWordWb", $sampled(expMemWord), $sampled(memWordWb));

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $finish;
    endtask

    // one instruction for one cycle with the rest of the payload random
    task automatic issue(input logic [31:0] instr, input logic [31:0] addr,
                         input logic [31:0] rtData, input logic [4:0] rtAddr,
                         input logic [4:0] wbAddr, input logic [31:0] wbData);
        instrMem        = instr;
        aluOutMem       = addr;
        dataRtMem       = rtData;
        addrRtMem       = rtAddr;
        regAddrWb       = wbAddr;
        regDataWb       = wbData;
        pcMem           = randBits(32) & 32'hffff_fffc;
        regWriteAddrMem = 5'(randBits(5));
        regWriteDataMem = randBits(32);
        tNewMem         = 2'(randBits(2));
        @(negedge clk);
    endtask

    function automatic logic [31:0] memInstr(input logic [5:0] op);
        return {op, 26'(randBits(26))};
    endfunction

    task automatic waitForWb(input logic [31:0] instr, input int limit);
        int cnt;
        cnt = 0;
        while (instrWb !== instr && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (instrWb !== instr) begin
            abortRun($sformatf("timeout: instruction %h never reached WB", instr));
        end
    endtask

    task automatic finishTest(input string name);
        int newErr;
        // two bubbles so late assertion hits land in this test
        issue(32'd0, 32'd0, 32'd0, 5'd0, 5'd0, 32'd0);
        issue(32'd0, 32'd0, 32'd0, 5'd0, 5'd0, 32'd0);
        newErr = errCount - errMark;
        errMark = errCount;
        testsRun++;
        if (newErr != 0) testsFailed++;
        $display("%-12s %s, %0d errors", name, (newErr == 0) ? "ok" : "FAILED", newErr);
    endtask

    initial begin : watchdog
        #(watchdogNs);
        abortRun("watchdog: simulation ran past its time limit");
    end

    initial begin : stimulus
        logic [31:0] a, b, d, ld;
        logic [4:0]  r;
        lfsr = 32'he2ea_9e3e;
        {rstN, stall, clr, chkOn} = 4'b0000;
        {instrMem, pcMem, aluOutMem, dataRtMem, regWriteDataMem, regDataWb} = '0;
        {addrRtMem, regWriteAddrMem, regAddrWb, tNewMem} = '0;
        repeat (5) @(negedge clk);
        rstN  = 1'b1;
        chkOn = 1'b1;

        // clear alone, then clear and reset under stall each after a fresh load
        repeat (3) issue({1'b0, 31'(randBits(31))}, randBits(32), 0, 0, 0, 0);
        clr = 1'b1;
        issue({1'b0, 31'(randBits(31))}, randBits(32), 0, 0, 0, 0);
        clr = 1'b0;
        issue({1'b0, 31'(randBits(31))}, randBits(32), 0, 0, 0, 0);
        {stall, clr} = 2'b11;
        issue({1'b0, 31'(randBits(31))}, randBits(32), 0, 0, 0, 0);
        {stall, clr} = 2'b00;
        issue({1'b0, 31'(randBits(31))}, randBits(32), 0, 0, 0, 0);
        {rstN, stall} = 2'b01;
        repeat (2) issue({1'b0, 31'(randBits(31))}, randBits(32), 0, 0, 0, 0);
        {rstN, stall} = 2'b10;
        finishTest("reset/clear");

        // fill pattern mixes every address bit
        for (int i = 0; i < 64; i++) begin
            a = 32'(i) << 2;
            issue(memInstr(opSw), a, a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9, 0, 0, 0);
        end
        for (int i = 0; i < 64; i++) issue(memInstr(opLw), 32'(i) << 2, 0, 0, 0, 0);
        finishTest("fill");

        for (int n = 0; n < 20; n++) begin
            a  = randBits(6) << 2;
            ld = memInstr(opLw);
            issue(memInstr(opSw), a, randBits(32), 5'(randBits(5)), 5'd0, randBits(32));
            issue(ld, a, 0, 0, 0, 0);
            waitForWb(ld, 4);
        end
        finishTest("word");

        // sub-word store then a sub-word load and a whole-word load of that word
        for (int n = 0; n < 30; n++) begin
            a = randBits(6) << 2;
            if (randBits(1) == 32'd1) issue(memInstr(opSh), a | (randBits(1) << 1),
                                            randBits(32), 0, 0, 0);
            else issue(memInstr(opSb), a | randBits(2), randBits(32), 0, 0, 0);
            case (2'(randBits(2)))
                2'd0: issue(memInstr(opLb), a | randBits(2), 0, 0, 0, 0);
                2'd1: issue(memInstr(opLbu), a | randBits(2), 0, 0, 0, 0);
                2'd2: issue(memInstr(opLh), a | (randBits(1) << 1), 0, 0, 0, 0);
                default: issue(memInstr(opLhu), a | (randBits(1) << 1), 0, 0, 0, 0);
            endcase
            ld = memInstr(opLw);
            issue(ld, a, 0, 0, 0, 0);
            waitForWb(ld, 4);
        end
        finishTest("subword");

        // matching, zero and mismatching WB register
        for (int n = 0; n < 8; n++) begin
            a = randBits(6) << 2;
            b = randBits(6) << 2;
            r = 5'(randBits(4)) + 5'd1;
            issue(memInstr(opSw), a, randBits(32), r, r, randBits(32));
            issue(memInstr(opLw), a, 0, 0, 0, 0);
            issue(memInstr(opSw), b, randBits(32), 5'd0, 5'd0, randBits(32));
            issue(memInstr(opLw), b, 0, 0, 0, 0);
            issue(memInstr(opSw), a, randBits(32), r, r + 5'd1, randBits(32));
            issue(memInstr(opLw), a, 0, 0, 0, 0);
        end
        finishTest("forwarding");

        // stores dropped while stalled and a store released when stall falls
        a = randBits(6) << 2;
        d = randBits(32);
        stall = 1'b1;
        repeat (3) issue(memInstr(opSw), a, randBits(32), 0, 0, 0);
        stall = 1'b0;
        issue(memInstr(opLw), a, 0, 0, 0, 0);
        stall = 1'b1;
        ld = memInstr(opSw);
        repeat (2) issue(ld, a, d, 0, 0, 0);
        stall = 1'b0;
        issue(ld, a, d, 0, 0, 0);
        ld = memInstr(opLw);
        issue(ld, a, 0, 0, 0, 0);
        waitForWb(ld, 4);
        finishTest("stall");

        for (int n = 0; n < 40; n++) begin
            issue({1'b0, 31'(randBits(31))}, randBits(32), randBits(32), 5'(randBits(5)),
                  5'(randBits(5)), randBits(32));
        end
        finishTest("passthrough");

        $display("summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/mipsPkg.sv
src/instrClass.sv
dm/dataMem.sv
src/memWbReg.sv
src/memStage.sv
bench/memStageTb.sv

// ==== Makefile ====
# Verilator build and run for the MIPS memory-access stage

VERILATOR ?= verilator
TOP       ?= memStageTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '^Test completed successfully$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
